// ==== src/ethernet_receive_package.sv ====
package ethernet_receive_package;

    // FCS and CRC width in bits
    localparam int crc_width = 32;

    typedef enum logic [1:0] {
        speed_10m     = 2'd0,
        speed_100m    = 2'd1,
        speed_gigabit = 2'd2
    } speed_t;

    // Byte from the PHY side with an edge flag on first and last byte
    typedef struct packed {
        logic       frame_edge;
        logic [7:0] value;
    } phy_byte_t;

    // Payload byte into the CRC engine
    typedef struct packed {
        logic       valid;
        logic       last;
        logic [7:0] value;
    } crc_byte_t;

    // Broadcast write to the slot buffers
    typedef struct packed {
        logic       valid;
        logic       start;
        logic [7:0] value;
    } slot_write_t;

endpackage

// ==== src/ethernet_crc32.sv ====
`timescale 1ns/1ns

module ethernet_crc32 (
    input  logic                                           clock,
    input  logic                                           reset_n,
    input  ethernet_receive_package::crc_byte_t            crc_byte,
    output logic [ethernet_receive_package::crc_width-1:0] crc_result,
    output logic                                           crc_result_valid
);

    localparam int width = ethernet_receive_package::crc_width;
    // Reflected form of 04C11DB7
    localparam logic [width-1:0] polynomial = 32'hEDB88320;

    logic [width-1:0] crc_state;
    logic [width-1:0] crc_update;
    logic [width-1:0] crc_final;
    logic [width-1:0] crc_inverted;

    // One byte with the LSB first
    always_comb begin
        crc_update = crc_state ^ width'(crc_byte.value);
        for (int bit_index = 0; bit_index < 8; bit_index++) begin
            if (crc_update[0]) begin
                crc_update = (crc_update >> 1) ^ polynomial;
            end else begin
                crc_update = crc_update >> 1;
            end
        end
    end

    // A timeout close can carry last without a byte
    assign crc_final    = crc_byte.valid ? crc_update : crc_state;
    assign crc_inverted = ~crc_final;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            crc_state        <= '1;
            crc_result_valid <= 1'b0;
        end else begin
            crc_result_valid <= crc_byte.last;
            if (crc_byte.last) begin
                crc_state <= '1;
            end else if (crc_byte.valid) begin
                crc_state <= crc_update;
            end
        end
    end

    // Wire order with the first transmitted byte on top
    always_ff @(posedge clock) begin
        if (crc_byte.last) begin
            crc_result <= {<<8{crc_inverted}};
        end
    end

endmodule

// ==== src/ethernet_packet_parser.sv ====
`timescale 1ns/1ns

module ethernet_packet_parser #(
    parameter int receive_slots = 2
) (
    input  logic                                          clock,
    input  logic                                          reset_n,
    input  ethernet_receive_package::phy_byte_t           phy_byte,
    input  logic                                          data_enable,
    input  ethernet_receive_package::speed_t              speed,
    input  logic [receive_slots-1:0]                      slot_free,
    input  logic [ethernet_receive_package::crc_width-1:0] crc_result,
    input  logic                                          crc_result_valid,
    output logic                                          data_ready,
    output ethernet_receive_package::crc_byte_t           crc_byte,
    output ethernet_receive_package::slot_write_t         slot_write,
    output logic [receive_slots-1:0]                      slot_select,
    output logic [receive_slots-1:0]                      commit,
    output logic [receive_slots-1:0]                      discard,
    output logic [receive_slots-1:0]                      good_packet,
    output logic [receive_slots-1:0]                      bad_packet
);

    localparam int fcs_width = ethernet_receive_package::crc_width;
    // Five or more bytes seen, so the CRC has at least one payload byte
    localparam logic [2:0] frame_full = 3'd5;

    typedef enum logic [1:0] {
        state_idle,
        state_parse,
        state_check,
        state_drop
    } parser_state_t;

    parser_state_t                          state;
    parser_state_t                          state_next;
    logic [5:0]                             idle_count;
    logic [5:0]                             idle_count_next;
    logic [5:0]                             timeout_limit;
    logic                                   timed_out;
    logic [2:0]                             byte_count;
    logic [2:0]                             byte_count_next;
    logic [fcs_width-1:0]                   fcs_shift;
    logic [fcs_width-1:0]                   fcs_shift_next;
    logic [receive_slots-1:0]               free_pick;
    logic [receive_slots-1:0]               slot_select_next;
    logic [receive_slots-1:0]               good_next;
    logic [receive_slots-1:0]               bad_next;
    ethernet_receive_package::crc_byte_t    crc_byte_next;
    ethernet_receive_package::slot_write_t  slot_write_next;
    logic                                   data_ready_next;
    logic                                   accept;

    assign accept = data_enable && data_ready;

    assign commit  = good_packet;
    assign discard = bad_packet;

    always_comb begin
        case (speed)
            ethernet_receive_package::speed_gigabit: timeout_limit = 6'd1;
            ethernet_receive_package::speed_100m:    timeout_limit = 6'd4;
            default:                                 timeout_limit = 6'd40;
        endcase
    end

    assign timed_out = (idle_count == timeout_limit - 6'd1);

    // Highest-index free slot wins
    always_comb begin
        free_pick = '0;
        for (int i = 0; i < receive_slots; i++) begin
            if (slot_free[i]) begin
                free_pick    = '0;
                free_pick[i] = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM

    always_comb begin
        state_next       = state;
        idle_count_next  = idle_count;
        byte_count_next  = byte_count;
        fcs_shift_next   = fcs_shift;
        slot_select_next = slot_select;
        crc_byte_next    = '0;
        slot_write_next  = '0;
        good_next        = '0;
        bad_next         = '0;

        case (state)
            state_idle: begin
                idle_count_next = '0;
                if (accept && phy_byte.frame_edge) begin
                    if (|slot_free) begin
                        state_next            = state_parse;
                        slot_select_next      = free_pick;
                        byte_count_next       = 3'd1;
                        fcs_shift_next        = {fcs_shift[fcs_width-9:0], phy_byte.value};
                        slot_write_next.valid = 1'b1;
                        slot_write_next.start = 1'b1;
                        slot_write_next.value = phy_byte.value;
                    end else begin
                        state_next = state_drop;
                    end
                end
            end
            state_parse: begin
                if (accept) begin
                    idle_count_next       = '0;
                    fcs_shift_next        = {fcs_shift[fcs_width-9:0], phy_byte.value};
                    slot_write_next.valid = 1'b1;
                    slot_write_next.value = phy_byte.value;
                    // The FCS register doubles as the four-byte delay line
                    if (byte_count >= 3'd4) begin
                        crc_byte_next.valid = 1'b1;
                        crc_byte_next.value = fcs_shift[fcs_width-1:fcs_width-8];
                    end
                    if (byte_count != frame_full) begin
                        byte_count_next = byte_count + 3'd1;
                    end
                    if (phy_byte.frame_edge) begin
                        crc_byte_next.last = 1'b1;
                        state_next         = state_check;
                    end
                end else if (timed_out) begin
                    // Stalled frame ends at the last byte received
                    crc_byte_next.last = 1'b1;
                    state_next         = state_check;
                end else begin
                    idle_count_next = idle_count + 6'd1;
                end
            end
            state_check: begin
                if (crc_result_valid) begin
                    state_next = state_idle;
                    if (byte_count == frame_full && crc_result == fcs_shift) begin
                        good_next = slot_select;
                    end else begin
                        bad_next = slot_select;
                    end
                end
            end
            state_drop: begin
                if (accept) begin
                    idle_count_next = '0;
                    if (phy_byte.frame_edge) begin
                        state_next = state_idle;
                    end
                end else if (timed_out) begin
                    state_next = state_idle;
                end else begin
                    idle_count_next = idle_count + 6'd1;
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase

        // Hold the stream off while a verdict is outstanding
        data_ready_next = (state_next != state_check);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state       <= state_idle;
            idle_count  <= '0;
            byte_count  <= '0;
            slot_select <= '0;
            crc_byte    <= '0;
            slot_write  <= '0;
            good_packet <= '0;
            bad_packet  <= '0;
            data_ready  <= 1'b0;
        end else begin
            state       <= state_next;
            idle_count  <= idle_count_next;
            byte_count  <= byte_count_next;
            slot_select <= slot_select_next;
            crc_byte    <= crc_byte_next;
            slot_write  <= slot_write_next;
            good_packet <= good_next;
            bad_packet  <= bad_next;
            data_ready  <= data_ready_next;
        end
    end

    always_ff @(posedge clock) begin
        fcs_shift <= fcs_shift_next;
    end

endmodule

// ==== src/receive_slot_buffer.sv ====
`timescale 1ns/1ns

module receive_slot_buffer #(
    parameter int slot_depth = 64
) (
    input  logic                                  clock,
    input  logic                                  reset_n,
    input  ethernet_receive_package::slot_write_t slot_write,
    input  logic                                  selected,
    input  logic                                  commit,
    input  logic                                  discard,
    input  logic                                  read_strobe,
    output logic                                  free,
    output logic                                  pending,
    output logic [7:0]                            read_data,
    output logic                                  read_valid,
    output logic                                  read_last
);

    localparam int address_width = (slot_depth > 1) ? $clog2(slot_depth) : 1;
    localparam int count_width   = $clog2(slot_depth + 1);

    logic [7:0]               memory [slot_depth];
    logic [count_width-1:0]   write_count;
    logic [count_width-1:0]   stored_length;
    logic [address_width-1:0] write_address;
    logic [address_width-1:0] read_pointer;
    logic                     free_q;
    logic                     write_enable;
    logic                     read_enable;
    logic                     read_final;

    // Bytes past the slot depth are dropped
    assign write_enable  = selected && slot_write.valid
                           && (slot_write.start || write_count < count_width'(slot_depth));
    assign write_address = slot_write.start ? '0 : write_count[address_width-1:0];

    assign read_enable = read_strobe && pending;
    assign read_final  = (count_width'(read_pointer) + count_width'(1) == stored_length);

    // Released slot visible in the discard cycle
    assign free = free_q || discard;

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_address] <= slot_write.value;
        end
        if (read_enable) begin
            read_data <= memory[read_pointer];
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_count   <= '0;
            stored_length <= '0;
            read_pointer  <= '0;
            free_q        <= 1'b1;
            pending       <= 1'b0;
            read_valid    <= 1'b0;
            read_last     <= 1'b0;
        end else begin
            read_valid <= read_enable;
            read_last  <= read_enable && read_final;

            if (write_enable) begin
                write_count <= slot_write.start ? count_width'(1) : write_count + 1'b1;
            end
            if (selected && slot_write.valid && slot_write.start) begin
                free_q <= 1'b0;
            end

            if (commit) begin
                stored_length <= write_count;
                read_pointer  <= '0;
                pending       <= 1'b1;
            end
            if (discard) begin
                free_q <= 1'b1;
            end

            // Readout returns the slot to free after the last byte
            if (read_enable) begin
                read_pointer <= read_pointer + 1'b1;
                if (read_final) begin
                    pending <= 1'b0;
                    free_q  <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/ethernet_receiver.sv ====
`timescale 1ns/1ns

module ethernet_receiver #(
    parameter int receive_slots = 2,
    parameter int slot_depth    = 64,
    localparam int select_width = (receive_slots > 1) ? $clog2(receive_slots) : 1
) (
    input  logic                                clock,
    input  logic                                reset_n,
    input  ethernet_receive_package::phy_byte_t phy_byte,
    input  logic                                data_enable,
    input  ethernet_receive_package::speed_t    speed,
    input  logic [select_width-1:0]             read_select,
    input  logic                                read_strobe,
    output logic                                data_ready,
    output logic [receive_slots-1:0]            good_packet,
    output logic [receive_slots-1:0]            bad_packet,
    output logic [receive_slots-1:0]            packet_pending,
    output logic [7:0]                          read_data,
    output logic                                read_valid,
    output logic                                read_last
);

    ethernet_receive_package::crc_byte_t            crc_byte;
    logic [ethernet_receive_package::crc_width-1:0] crc_result;
    logic                                           crc_result_valid;
    ethernet_receive_package::slot_write_t          slot_write;
    logic [receive_slots-1:0]                       slot_select;
    logic [receive_slots-1:0]                       commit;
    logic [receive_slots-1:0]                       discard;
    logic [receive_slots-1:0]                       slot_free;
    logic [7:0]                                     slot_read_data [receive_slots];
    logic [receive_slots-1:0]                       slot_read_valid;
    logic [receive_slots-1:0]                       slot_read_last;

    ethernet_packet_parser #(
        .receive_slots (receive_slots)
    ) parser (
        .clock            (clock),
        .reset_n          (reset_n),
        .phy_byte         (phy_byte),
        .data_enable      (data_enable),
        .speed            (speed),
        .slot_free        (slot_free),
        .crc_result       (crc_result),
        .crc_result_valid (crc_result_valid),
        .data_ready       (data_ready),
        .crc_byte         (crc_byte),
        .slot_write       (slot_write),
        .slot_select      (slot_select),
        .commit           (commit),
        .discard          (discard),
        .good_packet      (good_packet),
        .bad_packet       (bad_packet)
    );

    ethernet_crc32 crc (
        .clock            (clock),
        .reset_n          (reset_n),
        .crc_byte         (crc_byte),
        .crc_result       (crc_result),
        .crc_result_valid (crc_result_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Slot buffers

    for (genvar i = 0; i < receive_slots; i++) begin : slot
        receive_slot_buffer #(
            .slot_depth (slot_depth)
        ) buffer (
            .clock       (clock),
            .reset_n     (reset_n),
            .slot_write  (slot_write),
            .selected    (slot_select[i]),
            .commit      (commit[i]),
            .discard     (discard[i]),
            .read_strobe (read_strobe && read_select == select_width'(i)),
            .free        (slot_free[i]),
            .pending     (packet_pending[i]),
            .read_data   (slot_read_data[i]),
            .read_valid  (slot_read_valid[i]),
            .read_last   (slot_read_last[i])
        );
    end

    // Readout follows the selected slot
    always_comb begin
        read_data  = '0;
        read_valid = 1'b0;
        read_last  = 1'b0;
        for (int i = 0; i < receive_slots; i++) begin
            if (read_select == select_width'(i)) begin
                read_data  = slot_read_data[i];
                read_valid = slot_read_valid[i];
                read_last  = slot_read_last[i];
            end
        end
    end

endmodule

// ==== tb/ethernet_receiver_tb.sv ====
`timescale 1ns/1ns

module ethernet_receiver_tb;

    localparam int slot_count  = 2;
    localparam int select_bits = 1;
    // Well above the summed length of all tests
    localparam int cycle_limit = 4000;

    logic                                clock;
    logic                                reset_n;
    ethernet_receive_package::phy_byte_t phy_byte;
    logic                                data_enable;
    ethernet_receive_package::speed_t    speed;
    logic [select_bits-1:0]              read_select;
    logic                                read_strobe;
    logic                                data_ready;
    logic [slot_count-1:0]               good_packet;
    logic [slot_count-1:0]               bad_packet;
    logic [slot_count-1:0]               packet_pending;
    logic [7:0]                          read_data;
    logic                                read_valid;
    logic                                read_last;

    integer     seed;
    int         cycle_count = 0;
    int         verdict_count = 0;
    logic [7:0] frame_bytes[$];
    logic [7:0] expected_bytes[$];
    logic [7:0] frame_a[$];
    logic [7:0] frame_b[$];
    logic [7:0] frame_d[$];

    ethernet_receiver #(
        .receive_slots (slot_count),
        .slot_depth    (64)
    ) DUT (
        .clock          (clock),
        .reset_n        (reset_n),
        .phy_byte       (phy_byte),
        .data_enable    (data_enable),
        .speed          (speed),
        .read_select    (read_select),
        .read_strobe    (read_strobe),
        .data_ready     (data_ready),
        .good_packet    (good_packet),
        .bad_packet     (bad_packet),
        .packet_pending (packet_pending),
        .read_data      (read_data),
        .read_valid     (read_valid),
        .read_last      (read_last)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic report_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("The run did not finish within %0d cycles", cycle_limit);
            report_failure();
        end
    end

    // Counts verdict pulses of any slot
    always @(negedge clock) begin
        if (|good_packet || |bad_packet) begin
            verdict_count = verdict_count + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_slots(input string name, input logic [slot_count-1:0] expected,
                               input logic [slot_count-1:0] actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error: %s expected 0x%h actual 0x%h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_pending(input logic [slot_count-1:0] expected);
        @(negedge clock);
        check_slots("packet_pending", expected, packet_pending);
        @(posedge clock);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Random payload followed by its FCS with the low byte of the inverted CRC first
    task automatic make_frame(input int payload_length);
        logic [ethernet_receive_package::crc_width-1:0] crc;
        frame_bytes.delete();
        crc = '1;
        for (int i = 0; i < payload_length; i++) begin
            frame_bytes.push_back(8'($random(seed)));
            crc = crc ^ {24'h0, frame_bytes[i]};
            for (int b = 0; b < 8; b++) begin
                if (crc[0]) begin
                    crc = (crc >> 1) ^ 32'hEDB88320;
                end else begin
                    crc = crc >> 1;
                end
            end
        end
        crc = ~crc;
        for (int k = 0; k < ethernet_receive_package::crc_width / 8; k++) begin
            frame_bytes.push_back(crc[8*k +: 8]);
        end
    endtask

    task automatic send_byte(input logic edge_flag, input logic [7:0] byte_value);
        logic taken;
        phy_byte.frame_edge <= edge_flag;
        phy_byte.value      <= byte_value;
        data_enable         <= 1'b1;
        do begin
            @(negedge clock);
            taken = data_ready;
            @(posedge clock);
        end while (!taken);
    endtask

    task automatic send_frame(input int gap, input logic with_end);
        int   last_index;
        logic edge_flag;
        last_index = frame_bytes.size() - 1;
        for (int i = 0; i <= last_index; i++) begin
            edge_flag = (i == 0) || (with_end && i == last_index);
            send_byte(edge_flag, frame_bytes[i]);
            if (gap > 0 && i != last_index) begin
                data_enable <= 1'b0;
                repeat (gap) @(posedge clock);
            end
        end
        data_enable <= 1'b0;
    endtask

    task automatic wait_verdict(input logic [slot_count-1:0] good_expected,
                                input logic [slot_count-1:0] bad_expected, input int limit);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < limit) begin
            @(negedge clock);
            found = |good_packet || |bad_packet;
            if (found) begin
                check_slots("good_packet", good_expected, good_packet);
                check_slots("bad_packet", bad_expected, bad_packet);
            end
            @(posedge clock);
            cycles++;
        end
        if (!found) begin
            $display("No good or bad verdict arrived within %0d cycles", limit);
            report_failure();
        end
    endtask

    // Reads a whole slot with one strobe per byte
    task automatic read_slot(input int index);
        int   count;
        logic last_expected;
        count = expected_bytes.size();
        read_select <= select_bits'(index);
        for (int i = 0; i < count; i++) begin
            read_strobe <= 1'b1;
            @(posedge clock);
            read_strobe <= 1'b0;
            @(negedge clock);
            last_expected = (i == count - 1);
            check_bit("read_valid", 1'b1, read_valid);
            check_byte("read_data", expected_bytes[i], read_data);
            check_bit("read_last", last_expected, read_last);
            @(posedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests

    task automatic check_after_reset();
        @(posedge clock);
        @(negedge clock);
        check_slots("good_packet", '0, good_packet);
        check_slots("bad_packet", '0, bad_packet);
        check_slots("packet_pending", '0, packet_pending);
        check_bit("read_valid", 1'b0, read_valid);
        check_bit("data_ready", 1'b1, data_ready);
        @(posedge clock);
    endtask

    task automatic good_frame_gigabit();
        speed <= ethernet_receive_package::speed_gigabit;
        make_frame(20);
        send_frame(0, 1'b1);
        wait_verdict(2'b10, 2'b00, 16);
        check_pending(2'b10);
        expected_bytes = frame_bytes;
        read_slot(1);
    endtask

    task automatic bad_fcs_frame();
        int last_index;
        make_frame(20);
        last_index = frame_bytes.size() - 1;
        frame_bytes[last_index] = frame_bytes[last_index] ^ 8'h10;
        send_frame(0, 1'b1);
        wait_verdict(2'b00, 2'b10, 16);
        check_pending(2'b00);
        // Discarded slot is taken again
        make_frame(20);
        send_frame(0, 1'b1);
        wait_verdict(2'b10, 2'b00, 16);
        expected_bytes = frame_bytes;
        read_slot(1);
    endtask

    task automatic slots_full();
        int verdicts_before;
        make_frame(20);
        frame_a = frame_bytes;
        send_frame(0, 1'b1);
        wait_verdict(2'b10, 2'b00, 16);
        make_frame(20);
        frame_b = frame_bytes;
        send_frame(0, 1'b1);
        wait_verdict(2'b01, 2'b00, 16);
        check_pending(2'b11);
        // No free slot so this frame is dropped silently
        make_frame(20);
        verdicts_before = verdict_count;
        send_frame(0, 1'b1);
        repeat (8) @(posedge clock);
        check_bit("verdict_pulse", 1'b0, verdict_count != verdicts_before);
        check_pending(2'b11);
        expected_bytes = frame_b;
        read_slot(0);
        make_frame(20);
        frame_d = frame_bytes;
        send_frame(0, 1'b1);
        wait_verdict(2'b01, 2'b00, 16);
        expected_bytes = frame_a;
        read_slot(1);
        expected_bytes = frame_d;
        read_slot(0);
        check_pending(2'b00);
    endtask

    task automatic timeout_100m();
        int last_index;
        speed <= ethernet_receive_package::speed_100m;
        make_frame(20);
        // An intact FCS would still close good on a timeout
        last_index = frame_bytes.size() - 1;
        frame_bytes[last_index] = frame_bytes[last_index] ^ 8'h01;
        send_frame(0, 1'b0);
        wait_verdict(2'b00, 2'b10, 10);
        @(negedge clock);
        check_bit("data_ready", 1'b1, data_ready);
        @(posedge clock);
        check_pending(2'b00);
    endtask

    task automatic spaced_10m();
        speed <= ethernet_receive_package::speed_10m;
        make_frame(20);
        send_frame(20, 1'b1);
        wait_verdict(2'b10, 2'b00, 16);
        check_pending(2'b10);
        expected_bytes = frame_bytes;
        read_slot(1);
    endtask

    initial begin
        seed        = 32'h7f29e869;
        reset_n     = 1'b0;
        phy_byte    = '0;
        data_enable = 1'b0;
        speed       = ethernet_receive_package::speed_gigabit;
        read_select = '0;
        read_strobe = 1'b0;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;

        check_after_reset();
        good_frame_gigabit();
        bad_fcs_frame();
        slots_full();
        timeout_100m();
        spaced_10m();

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== compile.f ====
src/ethernet_receive_package.sv
src/ethernet_crc32.sv
src/ethernet_packet_parser.sv
src/receive_slot_buffer.sv
src/ethernet_receiver.sv
tb/ethernet_receiver_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary -Wno-fatal --top-module ethernet_receiver_tb \
    -f compile.f --Mdir obj_dir -o ethernet_receiver_sim \
    && ./obj_dir/ethernet_receiver_sim | grep "Regression passed" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
